/* hdl/dma_config.svh */
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Channel n always feeds sink n
`define DMA_CHANNELS 2

// Entries in the shared command table
`define DMA_CMD_DEPTH 8

// Word addresses on both FIFO sides
`define DMA_ADDR_W 32

`define DMA_DATA_W 32

// Word counts and FIFO block sizes
`define DMA_COUNT_W 24

`endif

/* hdl/dma_pkg.sv */
`include "dma_config.svh"

package dma_pkg;

  typedef logic [`DMA_ADDR_W-1:0] addr_t;
  typedef logic [`DMA_DATA_W-1:0] data_t;
  typedef logic [`DMA_COUNT_W-1:0] count_t;
  typedef logic [$clog2(`DMA_CMD_DEPTH)-1:0] ip_t;

  // One command table entry
  typedef struct packed {
    addr_t  src_addr;
    addr_t  dest_addr;
    count_t count;
    logic   cont;
    logic   src_rst;
    logic   dest_rst;
    ip_t    next;
  } cmd_t;

  typedef struct packed {
    logic enable;
    ip_t  start_ip;
    logic src_inc;
    logic src_dec;
    logic dest_inc;
    logic dest_dec;
  } chan_ctrl_t;

  typedef struct packed {
    logic busy;
    logic finished;
  } chan_status_t;

  typedef struct packed {
    logic   enable;
    addr_t  address;
    count_t count;
    logic   addr_inc;
    logic   addr_dec;
    logic   activate;
    logic   strobe;
    logic   flush;
  } src_req_t;

  typedef struct packed {
    logic   ready;
    count_t size;
    data_t  data;
  } src_rsp_t;

  // Sink side has two ping-pong halves
  typedef struct packed {
    logic       enable;
    addr_t      address;
    count_t     count;
    logic       addr_inc;
    logic       addr_dec;
    logic [1:0] activate;
    logic       strobe;
    data_t      data;
    logic       flush;
  } snk_req_t;

  typedef struct packed {
    logic [1:0] ready;
    count_t     size;
  } snk_rsp_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_CHANNEL,
    SETUP_COMMAND,
    ACTIVE,
    END_COMMAND,
    FLUSH,
    FINISHED
  } chan_state_t;

endpackage

/* hdl/dma_cmd_table.sv */
`timescale 1ns/1ns

`include "dma_config.svh"

module dma_cmd_table (
  input  logic          clk,
  input  logic          rst,
  input  logic          i_cmd_wr,
  input  dma_pkg::ip_t  i_cmd_addr,
  input  dma_pkg::cmd_t i_cmd,
  input  dma_pkg::ip_t  i_ip [`DMA_CHANNELS],
  output dma_pkg::cmd_t o_cmd [`DMA_CHANNELS]
);

  dma_pkg::cmd_t cmd_mem [`DMA_CMD_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `DMA_CMD_DEPTH; i++) begin
        cmd_mem[i] <= '0;
      end
    end else if (i_cmd_wr) begin
      cmd_mem[i_cmd_addr] <= i_cmd;
    end
  end

  // Each channel sees its current entry without delay
  always_comb begin
    for (int c = 0; c < `DMA_CHANNELS; c++) begin
      o_cmd[c] = cmd_mem[i_ip[c]];
    end
  end

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (rst)
    i_cmd_wr |-> !$isunknown(i_cmd_addr)
  ) else $error("command write with unknown address");

endmodule

/* hdl/dma_source_port.sv */
`timescale 1ns/1ns

module dma_source_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_load_addr,
  input  dma_pkg::addr_t    i_addr,
  input  logic              i_go,
  input  logic              i_drain,
  input  logic              i_inc,
  input  logic              i_dec,
  input  dma_pkg::src_rsp_t i_rsp,
  output dma_pkg::src_req_t o_req,
  output logic              o_block_empty,
  output logic              o_fire
);

  logic            activate_q;
  logic            strobe_q;
  logic            flush_q;
  dma_pkg::count_t blk_count_q;
  dma_pkg::addr_t  cur_addr_q;
  dma_pkg::addr_t  pub_addr_q;
  logic            words_left;
  logic            drain_strobe;

  assign words_left    = activate_q && (blk_count_q < i_rsp.size);
  assign o_fire        = words_left && i_go && !i_drain;
  // Drained words are read out but never reported
  assign drain_strobe  = words_left && i_drain;
  assign o_block_empty = !activate_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      activate_q  <= 1'b0;
      strobe_q    <= 1'b0;
      flush_q     <= 1'b0;
      blk_count_q <= '0;
      cur_addr_q  <= '0;
      pub_addr_q  <= '0;
    end else begin
      strobe_q <= o_fire || drain_strobe;
      flush_q  <= i_drain;
      if (o_fire || drain_strobe) begin
        blk_count_q <= blk_count_q + 1'b1;
      end
      if (o_fire) begin
        if (i_inc) begin
          cur_addr_q <= cur_addr_q + 1'b1;
        end else if (i_dec) begin
          cur_addr_q <= cur_addr_q - 1'b1;
        end
      end
      if (activate_q && !words_left) begin
        activate_q <= 1'b0;
        pub_addr_q <= cur_addr_q;
      end else if (!activate_q && i_go && i_rsp.ready) begin
        activate_q  <= 1'b1;
        blk_count_q <= '0;
      end
      // New command base wins over a publish on the same edge
      if (i_load_addr) begin
        cur_addr_q <= i_addr;
        pub_addr_q <= i_addr;
      end
    end
  end

  always_comb begin
    o_req.enable   = 1'b0;
    o_req.count    = '0;
    o_req.address  = pub_addr_q;
    o_req.addr_inc = i_inc;
    o_req.addr_dec = i_dec;
    o_req.activate = activate_q;
    o_req.strobe   = strobe_q;
    o_req.flush    = flush_q;
  end

  a_strobe_in_block: assert property (
    @(posedge clk) disable iff (rst)
    o_req.strobe |-> o_req.activate
  ) else $error("source strobe outside an open block");

endmodule

/* hdl/dma_sink_port.sv */
`timescale 1ns/1ns

module dma_sink_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_load_addr,
  input  dma_pkg::addr_t    i_addr,
  input  logic              i_run,
  input  logic              i_write,
  input  dma_pkg::data_t    i_data,
  input  logic              i_close,
  input  logic              i_inc,
  input  logic              i_dec,
  input  dma_pkg::snk_rsp_t i_rsp,
  output dma_pkg::snk_req_t o_req,
  output logic              o_room
);

  logic [1:0]      activate_q;
  logic            strobe_q;
  logic            enable_q;
  dma_pkg::data_t  data_q;
  dma_pkg::count_t blk_count_q;
  dma_pkg::count_t fill;
  dma_pkg::addr_t  cur_addr_q;
  dma_pkg::addr_t  pub_addr_q;
  logic            half_open;
  logic            close_now;

  assign half_open = |activate_q;
  // Word in flight already holds a slot
  assign fill      = blk_count_q + dma_pkg::count_t'(i_write);
  assign o_room    = half_open && (fill < i_rsp.size);

  // An empty half survives an end of command but not a flush
  assign close_now = half_open && !i_write &&
                     ((blk_count_q >= i_rsp.size) ||
                      (i_close && ((blk_count_q != '0) || !i_run)));

  always_ff @(posedge clk) begin
    if (rst) begin
      activate_q  <= 2'b00;
      strobe_q    <= 1'b0;
      enable_q    <= 1'b0;
      blk_count_q <= '0;
      cur_addr_q  <= '0;
      pub_addr_q  <= '0;
    end else begin
      strobe_q <= i_write;
      enable_q <= i_run || half_open;
      if (i_write) begin
        blk_count_q <= blk_count_q + 1'b1;
        if (i_inc) begin
          cur_addr_q <= cur_addr_q + 1'b1;
        end else if (i_dec) begin
          cur_addr_q <= cur_addr_q - 1'b1;
        end
      end
      if (!half_open) begin
        if (i_run && (i_rsp.ready != 2'b00)) begin
          activate_q  <= i_rsp.ready[0] ? 2'b01 : 2'b10;
          blk_count_q <= '0;
        end
      end else if (close_now) begin
        activate_q <= 2'b00;
        pub_addr_q <= cur_addr_q;
      end
      if (i_load_addr) begin
        cur_addr_q <= i_addr;
        pub_addr_q <= i_addr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_write) begin
      data_q <= i_data;
    end
  end

  always_comb begin
    o_req.enable   = enable_q;
    o_req.address  = pub_addr_q;
    o_req.count    = '0;
    o_req.addr_inc = i_inc;
    o_req.addr_dec = i_dec;
    o_req.activate = activate_q;
    o_req.strobe   = strobe_q;
    o_req.data     = data_q;
    o_req.flush    = 1'b0;
  end

  a_strobe_in_half: assert property (
    @(posedge clk) disable iff (rst)
    o_req.strobe |-> (o_req.activate != 2'b00)
  ) else $error("sink strobe with no active half");

endmodule

/* hdl/dma_channel.sv */
`timescale 1ns/1ns

module dma_channel (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_pkg::chan_ctrl_t   i_ctrl,
  input  dma_pkg::cmd_t         i_cmd,
  output dma_pkg::ip_t          o_ip,
  output dma_pkg::chan_status_t o_status,
  input  dma_pkg::src_rsp_t     i_src,
  output dma_pkg::src_req_t     o_src,
  input  dma_pkg::snk_rsp_t     i_snk,
  output dma_pkg::snk_req_t     o_snk
);

  dma_pkg::chan_state_t state_q;
  dma_pkg::ip_t         ip_q;
  dma_pkg::count_t      issued_q;
  logic                 fired_q;
  logic                 run_q;
  logic                 flush_q;
  dma_pkg::src_req_t    src_req;
  dma_pkg::snk_req_t    snk_req;
  logic                 words_due;
  logic                 src_load;
  logic                 snk_load;
  logic                 src_go;
  logic                 src_drain;
  logic                 src_empty;
  logic                 src_fire;
  logic                 snk_run;
  logic                 snk_close;
  logic                 snk_room;

  assign words_due = issued_q < i_cmd.count;

  assign src_load = (state_q == dma_pkg::SETUP_CHANNEL) ||
                    ((state_q == dma_pkg::SETUP_COMMAND) && i_cmd.src_rst);
  assign snk_load = (state_q == dma_pkg::SETUP_CHANNEL) ||
                    ((state_q == dma_pkg::SETUP_COMMAND) && i_cmd.dest_rst);

  // Strobe only with an open sink half that still has room
  assign src_go    = (state_q == dma_pkg::ACTIVE) && i_ctrl.enable && snk_room && words_due;
  assign src_drain = (state_q == dma_pkg::FLUSH);

  assign snk_run   = i_ctrl.enable && (state_q inside {dma_pkg::SETUP_COMMAND,
                                                       dma_pkg::ACTIVE,
                                                       dma_pkg::END_COMMAND});
  assign snk_close = (state_q == dma_pkg::END_COMMAND) || (state_q == dma_pkg::FLUSH);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= dma_pkg::IDLE;
      ip_q     <= '0;
      issued_q <= '0;
      fired_q  <= 1'b0;
      run_q    <= 1'b0;
      flush_q  <= 1'b0;
    end else begin
      fired_q <= src_fire;
      run_q   <= state_q inside {dma_pkg::SETUP_COMMAND, dma_pkg::ACTIVE,
                                 dma_pkg::END_COMMAND};
      flush_q <= (state_q == dma_pkg::FLUSH);
      if (src_fire) begin
        issued_q <= issued_q + 1'b1;
      end
      case (state_q)
        dma_pkg::IDLE: begin
          if (i_ctrl.enable) begin
            ip_q    <= i_ctrl.start_ip;
            state_q <= dma_pkg::SETUP_CHANNEL;
          end
        end
        dma_pkg::SETUP_CHANNEL: begin
          state_q <= dma_pkg::SETUP_COMMAND;
        end
        dma_pkg::SETUP_COMMAND: begin
          issued_q <= '0;
          state_q  <= dma_pkg::ACTIVE;
        end
        dma_pkg::ACTIVE: begin
          if (!i_ctrl.enable) begin
            state_q <= dma_pkg::FLUSH;
          end else if (!words_due && !fired_q) begin
            // Last word has reached the sink
            state_q <= dma_pkg::END_COMMAND;
          end
        end
        dma_pkg::END_COMMAND: begin
          if (i_cmd.cont) begin
            ip_q    <= i_cmd.next;
            state_q <= dma_pkg::SETUP_COMMAND;
          end else begin
            state_q <= dma_pkg::FLUSH;
          end
        end
        dma_pkg::FLUSH: begin
          if (src_empty && (snk_req.activate == 2'b00)) begin
            state_q <= dma_pkg::FINISHED;
          end
        end
        dma_pkg::FINISHED: begin
          if (!i_ctrl.enable) begin
            state_q <= dma_pkg::IDLE;
          end
        end
        default: begin
          state_q <= dma_pkg::IDLE;
        end
      endcase
    end
  end

  dma_source_port dma_source_port_i (
    .clk           (clk),
    .rst           (rst),
    .i_load_addr   (src_load),
    .i_addr        (i_cmd.src_addr),
    .i_go          (src_go),
    .i_drain       (src_drain),
    .i_inc         (i_ctrl.src_inc),
    .i_dec         (i_ctrl.src_dec),
    .i_rsp         (i_src),
    .o_req         (src_req),
    .o_block_empty (src_empty),
    .o_fire        (src_fire)
  );

  // Sink takes the word the source presents while its strobe is up
  dma_sink_port dma_sink_port_i (
    .clk         (clk),
    .rst         (rst),
    .i_load_addr (snk_load),
    .i_addr      (i_cmd.dest_addr),
    .i_run       (snk_run),
    .i_write     (fired_q),
    .i_data      (i_src.data),
    .i_close     (snk_close),
    .i_inc       (i_ctrl.dest_inc),
    .i_dec       (i_ctrl.dest_dec),
    .i_rsp       (i_snk),
    .o_req       (snk_req),
    .o_room      (snk_room)
  );

  always_comb begin
    o_src        = src_req;
    o_src.enable = run_q;
    o_src.count  = i_cmd.count;
    o_snk        = snk_req;
    o_snk.count  = i_cmd.count;
    o_snk.flush  = flush_q;
  end

  assign o_ip              = ip_q;
  assign o_status.busy     = (state_q != dma_pkg::IDLE);
  assign o_status.finished = (state_q == dma_pkg::FINISHED);

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/1ns

`include "dma_config.svh"

module dma_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_cmd_wr,
  input  dma_pkg::ip_t          i_cmd_addr,
  input  dma_pkg::cmd_t         i_cmd,
  input  dma_pkg::chan_ctrl_t   i_ctrl   [`DMA_CHANNELS],
  output dma_pkg::chan_status_t o_status [`DMA_CHANNELS],
  output dma_pkg::src_req_t     o_src    [`DMA_CHANNELS],
  input  dma_pkg::src_rsp_t     i_src    [`DMA_CHANNELS],
  output dma_pkg::snk_req_t     o_snk    [`DMA_CHANNELS],
  input  dma_pkg::snk_rsp_t     i_snk    [`DMA_CHANNELS]
);

  dma_pkg::ip_t  chan_ip  [`DMA_CHANNELS];
  dma_pkg::cmd_t chan_cmd [`DMA_CHANNELS];

  dma_cmd_table dma_cmd_table_i (
    .clk        (clk),
    .rst        (rst),
    .i_cmd_wr   (i_cmd_wr),
    .i_cmd_addr (i_cmd_addr),
    .i_cmd      (i_cmd),
    .i_ip       (chan_ip),
    .o_cmd      (chan_cmd)
  );

  // Channel n drives sink n
  for (genvar g = 0; g < `DMA_CHANNELS; g++) begin : g_chan
    dma_channel dma_channel_i (
      .clk      (clk),
      .rst      (rst),
      .i_ctrl   (i_ctrl[g]),
      .i_cmd    (chan_cmd[g]),
      .o_ip     (chan_ip[g]),
      .o_status (o_status[g]),
      .i_src    (i_src[g]),
      .o_src    (o_src[g]),
      .i_snk    (i_snk[g]),
      .o_snk    (o_snk[g])
    );
  end

endmodule

/* test/dma_checker.sv */
`timescale 1ns/1ns

`include "dma_config.svh"

module dma_checker (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_pkg::src_req_t     i_src_req [`DMA_CHANNELS],
  input  dma_pkg::src_rsp_t     i_src_rsp [`DMA_CHANNELS],
  input  dma_pkg::snk_req_t     i_snk_req [`DMA_CHANNELS],
  input  dma_pkg::snk_rsp_t     i_snk_rsp [`DMA_CHANNELS],
  input  dma_pkg::chan_status_t i_status  [`DMA_CHANNELS]
);

  // Expected words per channel, kept as a ring
  dma_pkg::data_t exp_mem [`DMA_CHANNELS][256];
  int             wr_cnt      [`DMA_CHANNELS];
  int             rd_cnt      [`DMA_CHANNELS];
  int             words       [`DMA_CHANNELS];
  int             flushes     [`DMA_CHANNELS];
  int             src_flushes [`DMA_CHANNELS];
  int             blk_words   [`DMA_CHANNELS];
  int             errors;
  string          test_name;

  initial begin
    errors    = 0;
    test_name = "reset";
    for (int c = 0; c < `DMA_CHANNELS; c++) begin
      wr_cnt[c]      = 0;
      rd_cnt[c]      = 0;
      words[c]       = 0;
      flushes[c]     = 0;
      src_flushes[c] = 0;
      blk_words[c]   = 0;
    end
  end

  task automatic start_test(input string name);
    test_name = name;
    for (int c = 0; c < `DMA_CHANNELS; c++) begin
      wr_cnt[c]      = 0;
      rd_cnt[c]      = 0;
      words[c]       = 0;
      flushes[c]     = 0;
      src_flushes[c] = 0;
    end
  endtask

  task automatic compare_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("ERROR %s %s: expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      for (int c = 0; c < `DMA_CHANNELS; c++) begin
        // Pop before push, the word in flight is always a cycle older
        if (i_snk_req[c].strobe) begin
          if (rd_cnt[c] == wr_cnt[c]) begin
            report_failure($sformatf("sink word on channel %0d with no source word", c));
          end else begin
            compare_value($sformatf("sink data ch%0d word %0d", c, rd_cnt[c]),
                          exp_mem[c][rd_cnt[c] % 256], i_snk_req[c].data);
            rd_cnt[c]++;
          end
          words[c]++;
          blk_words[c]++;
          if (i_snk_req[c].activate == 2'b00) begin
            report_failure($sformatf("sink strobe on channel %0d with no active half", c));
          end else if (blk_words[c] > i_snk_rsp[c].size) begin
            report_failure($sformatf("sink block on channel %0d overran its size", c));
          end
          if (!i_status[c].busy) begin
            report_failure($sformatf("sink word on channel %0d while not busy", c));
          end
        end
        if (i_snk_req[c].activate == 2'b00) begin
          blk_words[c] = 0;
        end
        if (i_snk_req[c].activate == 2'b11) begin
          report_failure($sformatf("both sink halves active on channel %0d", c));
        end
        if (i_src_req[c].strobe) begin
          exp_mem[c][wr_cnt[c] % 256] = i_src_rsp[c].data;
          wr_cnt[c]++;
        end
        if (i_snk_req[c].flush) begin
          flushes[c]++;
        end
        if (i_src_req[c].flush) begin
          src_flushes[c]++;
        end
      end
    end
  end

endmodule

/* test/tb_dma.sv */
`timescale 1ns/1ns

`include "dma_config.svh"

module tb_dma;

  logic                  clk;
  logic                  rst;
  logic                  cmd_wr;
  dma_pkg::ip_t          cmd_addr;
  dma_pkg::cmd_t         cmd;
  dma_pkg::chan_ctrl_t   ctrl    [`DMA_CHANNELS];
  dma_pkg::chan_status_t status  [`DMA_CHANNELS];
  dma_pkg::src_req_t     src_req [`DMA_CHANNELS];
  dma_pkg::src_rsp_t     src_rsp [`DMA_CHANNELS];
  dma_pkg::snk_req_t     snk_req [`DMA_CHANNELS];
  dma_pkg::snk_rsp_t     snk_rsp [`DMA_CHANNELS];
  logic                  src_taken [`DMA_CHANNELS];
  integer                seed;
  int                    pool [16];
  int                    tests_passed;
  int                    tests_failed;
  int                    err_start;
  string                 cur_test;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  dma_top dma_top_i (
    .clk        (clk),
    .rst        (rst),
    .i_cmd_wr   (cmd_wr),
    .i_cmd_addr (cmd_addr),
    .i_cmd      (cmd),
    .i_ctrl     (ctrl),
    .o_status   (status),
    .o_src      (src_req),
    .i_src      (src_rsp),
    .o_snk      (snk_req),
    .i_snk      (snk_rsp)
  );

  dma_checker dma_checker_i (
    .clk       (clk),
    .rst       (rst),
    .i_src_req (src_req),
    .i_src_rsp (src_rsp),
    .i_snk_req (snk_req),
    .i_snk_rsp (snk_rsp),
    .i_status  (status)
  );

  // FIFO models, sizes only change while no block is open
  always @(negedge clk) begin
    for (int c = 0; c < `DMA_CHANNELS; c++) begin
      if (src_taken[c]) begin
        src_rsp[c].data = $random(seed);
      end
      src_taken[c] = src_req[c].strobe;
      if (!src_req[c].activate) begin
        src_rsp[c].ready = (($random(seed) & 3) != 0);
        src_rsp[c].size  = 1 + ($random(seed) & 7);
      end
      if (snk_req[c].activate == 2'b00) begin
        snk_rsp[c].ready = $random(seed) & 3;
        snk_rsp[c].size  = 1 + ($random(seed) & 7);
      end
    end
  end

  task automatic write_entry(input dma_pkg::ip_t ip, input dma_pkg::addr_t src,
                             input dma_pkg::addr_t dest, input int count, input logic cont,
                             input logic src_rst, input logic dest_rst,
                             input dma_pkg::ip_t next);
    @(negedge clk);
    cmd_wr         = 1'b1;
    cmd_addr       = ip;
    cmd.src_addr   = src;
    cmd.dest_addr  = dest;
    cmd.count      = count;
    cmd.cont       = cont;
    cmd.src_rst    = src_rst;
    cmd.dest_rst   = dest_rst;
    cmd.next       = next;
    @(negedge clk);
    cmd_wr = 1'b0;
  endtask

  task automatic set_ctrl(input int ch, input logic en, input dma_pkg::ip_t ip,
                          input logic s_inc, input logic s_dec,
                          input logic d_inc, input logic d_dec);
    ctrl[ch].enable   = en;
    ctrl[ch].start_ip = ip;
    ctrl[ch].src_inc  = s_inc;
    ctrl[ch].src_dec  = s_dec;
    ctrl[ch].dest_inc = d_inc;
    ctrl[ch].dest_dec = d_dec;
  endtask

  task automatic wait_status(input int ch, input logic busy, input logic finished,
                             input int limit, input string what);
    int k;
    k = 0;
    while (!(status[ch].busy == busy && status[ch].finished == finished) && k < limit) begin
      @(negedge clk);
      k++;
    end
    if (!(status[ch].busy == busy && status[ch].finished == finished)) begin
      dma_checker_i.report_failure($sformatf("timeout waiting for %s on channel %0d",
                                             what, ch));
    end
  endtask

  task automatic wait_words(input int ch, input int n, input int limit);
    int k;
    k = 0;
    while (dma_checker_i.words[ch] < n && k < limit) begin
      @(negedge clk);
      k++;
    end
    if (dma_checker_i.words[ch] < n) begin
      dma_checker_i.report_failure($sformatf("timeout waiting for %0d words on channel %0d",
                                             n, ch));
    end
  endtask

  task automatic run_chain(input int ch, input dma_pkg::ip_t ip, input logic s_inc,
                           input logic s_dec, input logic d_inc, input logic d_dec);
    @(negedge clk);
    set_ctrl(ch, 1'b1, ip, s_inc, s_dec, d_inc, d_dec);
    wait_status(ch, 1'b1, 1'b1, 5000, "finished");
    @(negedge clk);
    ctrl[ch].enable = 1'b0;
    wait_status(ch, 1'b0, 1'b0, 10, "idle");
  endtask

  task automatic check_result(input int ch, input dma_pkg::addr_t src,
                              input dma_pkg::addr_t dest, input int n);
    dma_checker_i.compare_value($sformatf("word count ch%0d", ch), n,
                                dma_checker_i.words[ch]);
    dma_checker_i.compare_value($sformatf("source address ch%0d", ch), src,
                                src_req[ch].address);
    dma_checker_i.compare_value($sformatf("sink address ch%0d", ch), dest,
                                snk_req[ch].address);
    dma_checker_i.compare_value($sformatf("source enable when idle ch%0d", ch), 0,
                                src_req[ch].enable);
    dma_checker_i.compare_value($sformatf("sink enable when idle ch%0d", ch), 0,
                                snk_req[ch].enable);
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    err_start = dma_checker_i.errors;
    dma_checker_i.start_test(name);
  endtask

  task automatic end_test();
    if (dma_checker_i.errors == err_start) begin
      tests_passed++;
      $display("%s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", cur_test, dma_checker_i.errors - err_start);
    end
  endtask

  initial begin
    int a;
    int b;
    int c;
    int d;
    int n;
    dma_pkg::addr_t exp_src;
    dma_pkg::addr_t exp_dest;
    seed         = 32'h1fbe1de1;
    tests_passed = 0;
    tests_failed = 0;
    rst          = 1'b1;
    cmd_wr       = 1'b0;
    cmd_addr     = '0;
    cmd          = '0;
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      ctrl[i]          = '0;
      src_rsp[i]       = '0;
      snk_rsp[i]       = '0;
      src_rsp[i].data  = $random(seed);
      src_taken[i]     = 1'b0;
    end
    for (int i = 0; i < 16; i++) begin
      pool[i] = $random(seed);
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test("status_abort");
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      dma_checker_i.compare_value("busy after reset", 0, status[i].busy);
      dma_checker_i.compare_value("finished after reset", 0, status[i].finished);
      dma_checker_i.compare_value("source activate after reset", 0, src_req[i].activate);
      dma_checker_i.compare_value("sink activate after reset", 0, snk_req[i].activate);
      dma_checker_i.compare_value("sink flush after reset", 0, snk_req[i].flush);
    end
    write_entry(0, 32'h100, 32'h2000, 200, 1'b0, 1'b1, 1'b1, 0);
    @(negedge clk);
    set_ctrl(0, 1'b1, 0, 1'b1, 1'b0, 1'b1, 1'b0);
    wait_status(0, 1'b1, 1'b0, 4, "busy");
    wait_words(0, 4, 1000);
    @(negedge clk);
    ctrl[0].enable = 1'b0;
    // Enable is already low, so finished lasts a single cycle
    wait_status(0, 1'b1, 1'b1, 400, "finished");
    wait_status(0, 1'b0, 1'b0, 10, "idle");
    if (dma_checker_i.flushes[0] == 0) begin
      dma_checker_i.report_failure("no flush pulses after enable dropped");
    end
    if (dma_checker_i.src_flushes[0] == 0) begin
      dma_checker_i.report_failure("no source flush pulses after enable dropped");
    end
    if (dma_checker_i.words[0] >= 200) begin
      dma_checker_i.report_failure("abort still delivered the whole command");
    end
    end_test();

    begin_test("single_command");
    n = 3 + (pool[1] & 15);
    write_entry(1, 32'h1000, 32'h8_0000, n, 1'b0, 1'b1, 1'b1, 0);
    run_chain(0, 1, 1'b1, 1'b0, 1'b1, 1'b0);
    check_result(0, 32'h1000 + n, 32'h8_0000 + n, n);
    end_test();

    begin_test("chaining");
    a = 2 + (pool[2] & 7);
    b = 2 + (pool[3] & 7);
    c = 2 + (pool[4] & 7);
    write_entry(2, 32'h300, 32'h4000, a, 1'b1, 1'b1, 1'b1, 3);
    write_entry(3, 32'hdead, 32'h5000, b, 1'b1, 1'b0, 1'b1, 4);
    write_entry(4, 32'hbeef, 32'h6000, c, 1'b0, 1'b0, 1'b1, 0);
    run_chain(0, 2, 1'b1, 1'b0, 1'b1, 1'b0);
    check_result(0, 32'h300 + a + b + c, 32'h6000 + c, a + b + c);
    end_test();

    begin_test("addressing");
    n = 4 + (pool[5] & 15);
    write_entry(5, 32'h8000, 32'h9000, n, 1'b0, 1'b1, 1'b1, 0);
    for (int m = 0; m < 3; m++) begin
      dma_checker_i.start_test($sformatf("addressing mode %0d", m));
      run_chain(0, 5, m == 0, m == 1, m == 0, m == 1);
      exp_src  = (m == 0) ? 32'h8000 + n : ((m == 1) ? 32'h8000 - n : 32'h8000);
      exp_dest = (m == 0) ? 32'h9000 + n : ((m == 1) ? 32'h9000 - n : 32'h9000);
      check_result(0, exp_src, exp_dest, n);
    end
    end_test();

    begin_test("back_pressure");
    n = 100 + (pool[6] & 63);
    write_entry(6, 32'h0, 32'h10, n, 1'b0, 1'b1, 1'b1, 0);
    run_chain(1, 6, 1'b1, 1'b0, 1'b1, 1'b0);
    check_result(1, n, 32'h10 + n, n);
    end_test();

    begin_test("independence");
    a = 5 + (pool[7] & 15);
    b = 5 + (pool[8] & 15);
    c = 5 + (pool[9] & 15);
    d = 5 + (pool[10] & 15);
    write_entry(0, 32'h1_0000, 32'h2_0000, a, 1'b1, 1'b1, 1'b1, 1);
    write_entry(1, 32'h0, 32'h0, b, 1'b0, 1'b0, 1'b0, 0);
    write_entry(6, 32'h3_0000, 32'h4_0000, c, 1'b1, 1'b1, 1'b1, 7);
    write_entry(7, 32'h0, 32'h0, d, 1'b0, 1'b0, 1'b0, 0);
    @(negedge clk);
    set_ctrl(0, 1'b1, 0, 1'b1, 1'b0, 1'b1, 1'b0);
    set_ctrl(1, 1'b1, 6, 1'b0, 1'b1, 1'b0, 1'b1);
    wait_status(0, 1'b1, 1'b1, 5000, "finished");
    wait_status(1, 1'b1, 1'b1, 5000, "finished");
    @(negedge clk);
    ctrl[0].enable = 1'b0;
    ctrl[1].enable = 1'b0;
    wait_status(0, 1'b0, 1'b0, 10, "idle");
    wait_status(1, 1'b0, 1'b0, 10, "idle");
    check_result(0, 32'h1_0000 + a + b, 32'h2_0000 + a + b, a + b);
    check_result(1, 32'h3_0000 - (c + d), 32'h4_0000 - (c + d), c + d);
    end_test();

    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && dma_checker_i.errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hdl
hdl/dma_pkg.sv
hdl/dma_cmd_table.sv
hdl/dma_source_port.sv
hdl/dma_sink_port.sv
hdl/dma_channel.sv
hdl/dma_top.sv
test/dma_checker.sv
test/tb_dma.sv
